// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module regf_tb -Mdir obj_dir
	./obj_dir/Vregf_tb | tee /dev/stderr | grep "RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

// File: bench/regf_asserts.sv
// Concurrent checks on the register storage, strobes, hot-join bits and write landing
`timescale 1ns/10ps

module regf_asserts #(
  parameter int REGF_DEPTH = 512
) (
  input  logic                 i_regf_clk,
  input  logic                 i_regf_rst_n,
  input  logic                 i_rd,                // Forwarded read strobe
  input  logic                 i_wr,                // Forwarded write strobe
  input  regf_pkg::regf_addr_t i_addr,
  input  regf_pkg::regf_byte_t i_wdata,
  input  regf_pkg::regf_byte_t i_mem [REGF_DEPTH]  // Storage array
);

  import regf_pkg::*;

  logic settled;    // High from the first edge after reset
  logic plain_wr;   // Write to a byte without forced bits
  int   n_strobe_fail = 0;
  int   n_hj_fail     = 0;
  int   n_land_fail   = 0;

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      settled <= 1'b0;
    end
    else
    begin
      settled <= 1'b1;
    end
  end

  assign plain_wr = i_wr && (i_addr != ADDR_ENEC_BYTE) && (i_addr != ADDR_DISEC_BYTE)
                    && (int'(i_addr) < REGF_DEPTH);

  //////////////////// Strobes
  a_one_strobe: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    !(i_rd && i_wr))
  else
  begin
    n_strobe_fail++;
    $error("forwarded read and write strobes high together");
  end

  //////////////////// Hot-join bits
  // ENHJ and DISHJ always opposite
  a_hj_opposite: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    settled |-> (i_mem[ADDR_ENEC_BYTE][HJ_BIT] != i_mem[ADDR_DISEC_BYTE][HJ_BIT]))
  else
  begin
    n_hj_fail++;
    $error("ENEC and DISEC defining bits are equal");
  end

  //////////////////// Write landing
  a_write_lands: assert property (@(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    plain_wr |=> (i_mem[$past(i_addr)] == $past(i_wdata)))
  else
  begin
    n_land_fail++;
    $error("forwarded write data missing from the array one cycle later");
  end

endmodule

bind regf_storage regf_asserts #(
  .REGF_DEPTH (REGF_DEPTH)
) u_asserts (
  .i_regf_clk   (i_regf_clk),
  .i_regf_rst_n (i_regf_rst_n),
  .i_rd         (acc.rd),
  .i_wr         (acc.wr),
  .i_addr       (acc.addr),
  .i_wdata      (acc.wdata),
  .i_mem        (mem)
);

// File: bench/regf_tb.sv
// Directed testbench for the register file, defaults, host access, hot-join and decode
`timescale 1ns/10ps

module regf_tb;

  import regf_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int RW_COUNT   = 20;  // Random write and read pairs
  // Cycle estimate per test, reset, defaults, status, then tests 2 to 5
  localparam int CYCLE_BUDGET = 4 + 25*4 + 8 + RW_COUNT*6 + 30 + 40 + 4 + 2*30;
  localparam int MARGIN_NS    = 100 * CLK_PERIOD;
  // Dummy descriptor bytes, byte 0 in the low bits
  localparam logic [63:0] DUMMY_BYTES = 64'h00000000_18008F81;

  logic        clk;
  logic        rst_n;
  logic        rd_en;
  logic        wr_en;
  regf_addr_t  addr;
  regf_byte_t  data_wr;
  regf_byte_t  data_rd;
  regf_addr_t  engine_cfg;   // Descriptor base
  regf_byte_t  num_frames;
  logic        ser_rx_tx;
  logic [2:0]  hj_cfg;
  logic        hj_support;
  logic [15:0] data_len;
  logic [2:0]  cmd_attr;
  logic [3:0]  engine_tid;
  logic [7:0]  ccc_cmd;
  logic        engine_cp;
  logic [4:0]  dev_index;
  logic [2:0]  frmcnt_dtt;
  logic [2:0]  engine_mode;
  logic        cmd_rnw;
  logic        cmd_wroc;
  logic        cmd_toc;
  logic        cmd_dbp;
  logic        cmd_sre;
  integer      seed;

  regf_top #(
    .REGF_DEPTH (512)
  ) uut (
    .i_regf_clk             (clk),
    .i_regf_rst_n           (rst_n),
    .i_regf_rd_en           (rd_en),
    .i_regf_wr_en           (wr_en),
    .i_regf_addr            (addr),
    .i_regf_data_wr         (data_wr),
    .o_regf_data_rd         (data_rd),
    .i_engine_configuration (engine_cfg),
    .o_regf_num_frames      (num_frames),
    .o_ser_rx_tx            (ser_rx_tx),
    .o_regf_hj_cfg          (hj_cfg),
    .o_regf_hj_support      (hj_support),
    .o_frmcnt_data_len      (data_len),
    .o_cmd_attr             (cmd_attr),
    .o_engine_tid           (engine_tid),
    .o_ccc_cmd              (ccc_cmd),
    .o_engine_cp            (engine_cp),
    .o_dev_index            (dev_index),
    .o_frmcnt_dtt           (frmcnt_dtt),
    .o_engine_mode          (engine_mode),
    .o_cmd_rnw              (cmd_rnw),
    .o_cmd_wroc             (cmd_wroc),
    .o_cmd_toc              (cmd_toc),
    .o_cmd_dbp              (cmd_dbp),
    .o_cmd_sre              (cmd_sre)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  // Run length bound
  initial
  begin
    #(CYCLE_BUDGET * CLK_PERIOD + MARGIN_NS);
    $display("Watchdog expired before the tests completed");
    $display("RESULT: FAIL");
    $fatal(1, "simulation timed out");
  end

  //////////////////// Compare tasks
  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Fail at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
    $display("RESULT: FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic check_byte(input string name, input regf_byte_t exp, input regf_byte_t act);
    if (act !== exp)
    begin
      report_mismatch(name, 32'(exp), 32'(act));
    end
  endtask

  task automatic check_field(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    if (act !== exp)
    begin
      report_mismatch(name, 32'(exp), 32'(act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      report_mismatch(name, 32'(exp), 32'(act));
    end
  endtask

  //////////////////// Bus tasks
  task automatic write_byte(input regf_addr_t a, input regf_byte_t d);
    @(posedge clk);
    wr_en   <= 1'b1;
    rd_en   <= 1'b0;
    addr    <= a;
    data_wr <= d;
    @(posedge clk);  // Strobe taken here
    wr_en <= 1'b0;
  endtask

  // Data valid after the second edge from the strobe
  task automatic read_byte(input regf_addr_t a, output regf_byte_t d);
    @(posedge clk);
    rd_en <= 1'b1;
    wr_en <= 1'b0;
    addr  <= a;
    @(posedge clk);
    rd_en <= 1'b0;
    @(posedge clk);  // Read data loaded
    @(negedge clk);
    d = data_rd;
  endtask

  task automatic expect_byte(input regf_addr_t a, input regf_byte_t exp);
    regf_byte_t d;
    read_byte(a, d);
    check_byte($sformatf("o_regf_data_rd (addr %0d)", a), exp, d);
  endtask

  // Both strobes in one cycle
  task automatic collide(input regf_addr_t a, input regf_byte_t d);
    @(posedge clk);
    rd_en   <= 1'b1;
    wr_en   <= 1'b1;
    addr    <= a;
    data_wr <= d;
    @(posedge clk);
    rd_en <= 1'b0;
    wr_en <= 1'b0;
    @(posedge clk);
    @(negedge clk);
  endtask

  // Fields registered one edge after the base changes
  task automatic select_base(input regf_addr_t base);
    @(posedge clk);
    engine_cfg <= base;
    @(posedge clk);
    @(negedge clk);
  endtask

  //////////////////// Helpers
  // Hot-join bytes and the dummy descriptor stay untouched by random writes
  function automatic logic is_reserved(input regf_addr_t a);
    return ((a >= ADDR_ENEC_CCC) && (a <= ADDR_CRCAP1)) ||
           ((a >= ADDR_DUMMY_DESC) && (a <= ADDR_DUMMY_DESC + 9'd7));
  endfunction

  function automatic regf_addr_t pick_free_addr();
    logic [31:0] rnd;
    regf_addr_t  a;
    rnd = $random(seed);
    a   = rnd[8:0];
    while (is_reserved(a))
    begin
      rnd = $random(seed);
      a   = rnd[8:0];
    end
    return a;
  endfunction

  // Expected fields from the eight descriptor bytes
  task automatic check_descriptor(input logic [63:0] desc);
    logic [31:0] w0;
    logic [31:0] w1;
    logic        imm;
    w0  = desc[31:0];
    w1  = desc[63:32];
    imm = w0[0];  // Attribute bit 0
    check_field("o_frmcnt_data_len", w1[31:16], data_len);
    check_field("o_cmd_attr", 16'(w0[2:0]), 16'(cmd_attr));
    check_field("o_engine_tid", 16'(w0[6:3]), 16'(engine_tid));
    check_field("o_ccc_cmd", 16'(w0[14:7]), 16'(ccc_cmd));
    check_bit("o_engine_cp", w0[15], engine_cp);
    check_field("o_dev_index", 16'(w0[20:16]), 16'(dev_index));
    check_field("o_engine_mode", 16'(w0[28:26]), 16'(engine_mode));
    check_bit("o_cmd_rnw", w0[29], cmd_rnw);
    check_bit("o_cmd_wroc", w0[30], cmd_wroc);
    check_bit("o_cmd_toc", w0[31], cmd_toc);
    if (imm)
    begin
      check_field("o_frmcnt_dtt", 16'(w0[25:23]), 16'(frmcnt_dtt));
      check_bit("o_cmd_dbp", 1'b0, cmd_dbp);
      check_bit("o_cmd_sre", 1'b0, cmd_sre);
    end
    else
    begin
      check_field("o_frmcnt_dtt", 16'h0, 16'(frmcnt_dtt));
      check_bit("o_cmd_dbp", w0[25], cmd_dbp);
      check_bit("o_cmd_sre", w0[24], cmd_sre);
    end
  endtask

  //////////////////// Tests
  task automatic check_reset_state();
    check_byte("o_regf_data_rd", 8'h00, data_rd);
    check_byte("o_regf_num_frames", 8'h00, num_frames);
    check_bit("o_ser_rx_tx", 1'b0, ser_rx_tx);
    check_field("o_frmcnt_data_len", 16'h0, data_len);
    check_field("o_ccc_cmd", 16'h0, 16'(ccc_cmd));
    check_field("o_cmd_attr", 16'h0, 16'(cmd_attr));
  endtask

  task automatic test_defaults();
    expect_byte(ADDR_TARGET, 8'hA8);
    expect_byte(ADDR_NUM_FRAMES, 8'h02);
    expect_byte(ADDR_BDCST_WR, 8'hFC);
    expect_byte(ADDR_BDCST_RD, 8'hFD);
    expect_byte(ADDR_ENTDAA, 8'h07);
    expect_byte(ADDR_ENEC_CCC, 8'h00);
    expect_byte(ADDR_ENEC_BYTE, 8'h03);   // ENHJ cleared, no capability
    expect_byte(ADDR_DISEC_CCC, 8'h01);
    expect_byte(ADDR_DISEC_BYTE, 8'h08);  // DISHJ set
    expect_byte(ADDR_HJ_CFG, 8'h07);
    expect_byte(ADDR_CRCAP1, 8'h00);
    for (int k = 0; k < 8; k++)
    begin
      expect_byte(ADDR_DUMMY_DESC + regf_addr_t'(k), DUMMY_BYTES[8*k +: 8]);
    end
    expect_byte(9'd100, 8'h00);
    expect_byte(9'd511, 8'h00);
    check_byte("o_regf_num_frames", 8'h02, num_frames);
    check_bit("o_ser_rx_tx", 1'b0, ser_rx_tx);
    check_field("o_regf_hj_cfg", 16'h7, 16'(hj_cfg));
    check_bit("o_regf_hj_support", 1'b0, hj_support);
  endtask

  // Status registers trail the array by one edge
  task automatic test_status();
    write_byte(ADDR_TARGET, 8'hA9);      // RnW set, RX direction
    write_byte(ADDR_NUM_FRAMES, 8'h05);
    @(posedge clk);  // Frame count lands in the array
    @(negedge clk);
    check_bit("o_ser_rx_tx", 1'b1, ser_rx_tx);
    check_byte("o_regf_num_frames", 8'h02, num_frames);
    @(posedge clk);
    @(negedge clk);
    check_byte("o_regf_num_frames", 8'h05, num_frames);
  endtask

  task automatic test_write_read();
    regf_addr_t  a;
    regf_addr_t  b;
    regf_byte_t  d;
    logic [31:0] rnd;
    for (int n = 0; n < RW_COUNT; n++)
    begin
      a   = pick_free_addr();
      rnd = $random(seed);
      d   = rnd[7:0];
      write_byte(a, d);
      expect_byte(a, d);
    end
    // Collision keeps the target byte and the last read data
    a   = pick_free_addr();
    b   = pick_free_addr();
    while (b == a)
    begin
      b = pick_free_addr();
    end
    rnd = $random(seed);
    d   = rnd[7:0];
    write_byte(a, d);
    write_byte(b, ~d);
    expect_byte(b, ~d);
    collide(a, ~d);
    check_byte("o_regf_data_rd", ~d, data_rd);
    expect_byte(a, d);
  endtask

  task automatic test_hot_join();
    regf_byte_t d;
    write_byte(ADDR_HJ_CFG, 8'h07);  // Bit 1 enables hot-join
    write_byte(ADDR_CRCAP1, 8'h01);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_bit("o_regf_hj_support", 1'b1, hj_support);
    read_byte(ADDR_ENEC_BYTE, d);
    check_bit("o_regf_data_rd[3] (ENEC)", 1'b1, d[HJ_BIT]);
    read_byte(ADDR_DISEC_BYTE, d);
    check_bit("o_regf_data_rd[3] (DISEC)", 1'b0, d[HJ_BIT]);
    write_byte(ADDR_HJ_CFG, 8'h05);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_field("o_regf_hj_cfg", 16'h5, 16'(hj_cfg));
    read_byte(ADDR_ENEC_BYTE, d);
    check_bit("o_regf_data_rd[3] (ENEC)", 1'b0, d[HJ_BIT]);
    read_byte(ADDR_DISEC_BYTE, d);
    check_bit("o_regf_data_rd[3] (DISEC)", 1'b1, d[HJ_BIT]);
    // Host write loses bit 3 to the forced value
    write_byte(ADDR_ENEC_BYTE, 8'hFF);
    expect_byte(ADDR_ENEC_BYTE, 8'hF7);
  endtask

  task automatic test_descriptor(input regf_addr_t base, input logic imm);
    logic [63:0] desc;
    logic [31:0] rnd;
    for (int k = 0; k < 8; k++)
    begin
      rnd             = $random(seed);
      desc[8*k +: 8] = rnd[7:0];
    end
    desc[0] = imm;
    for (int k = 0; k < 8; k++)
    begin
      write_byte(base + regf_addr_t'(k), desc[8*k +: 8]);
    end
    select_base(base);
    check_descriptor(desc);
  endtask

  function automatic int assert_failures();
    return uut.u_storage.u_asserts.n_strobe_fail + uut.u_storage.u_asserts.n_hj_fail
           + uut.u_storage.u_asserts.n_land_fail;
  endfunction

  //////////////////// Main sequence
  initial
  begin
    seed       = 2202;
    rst_n      = 1'b0;
    rd_en      = 1'b0;
    wr_en      = 1'b0;
    addr       = '0;
    data_wr    = '0;
    engine_cfg = '0;
    @(posedge clk);
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    rst_n <= 1'b1;  // Two cycles of reset

    test_defaults();
    test_status();
    test_write_read();
    test_hot_join();
    select_base(ADDR_DUMMY_DESC);
    check_descriptor(DUMMY_BYTES);
    test_descriptor(9'd300, 1'b0);  // Regular view
    test_descriptor(9'd320, 1'b1);  // Immediate view

    if (assert_failures() == 0)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("Concurrent assertions reported %0d failures", assert_failures());
      $display("RESULT: FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// File: list.f
+incdir+source
source/regf_pkg.sv
source/regf_access_if.sv
source/regf_host_port.sv
source/regf_storage.sv
source/regf_cmd_decode.sv
source/regf_top.sv
bench/regf_asserts.sv
bench/regf_tb.sv

// File: source/regf_access_if.sv
// Host access channel between the access port and the register storage
`timescale 1ns/10ps

interface regf_access_if;

  import regf_pkg::*;

  logic       rd;     // Registered read strobe
  logic       wr;     // Registered write strobe
  regf_addr_t addr;   // Byte address of the access
  regf_byte_t wdata;  // Write byte
  regf_byte_t rdata;  // Read byte, held between reads

  // Access port side, at most one strobe high per cycle
  modport host (
    output rd,
    output wr,
    output addr,
    output wdata,
    input  rdata
  );

  // Storage side
  modport store (
    input  rd,
    input  wr,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: source/regf_cmd_decode.sv
// Command descriptor decoder, registers fields of immediate and regular commands
`timescale 1ns/10ps

module regf_cmd_decode (
  input  logic                  i_regf_clk,
  input  logic                  i_regf_rst_n,
  input  regf_pkg::regf_dword_t i_desc_word0,       // Command word
  input  regf_pkg::regf_dword_t i_desc_word1,       // Length word
  output logic [15:0]           o_frmcnt_data_len,
  output logic [2:0]            o_cmd_attr,
  output logic [3:0]            o_engine_tid,
  output logic [7:0]            o_ccc_cmd,
  output logic                  o_engine_cp,
  output logic [4:0]            o_dev_index,
  output logic [2:0]            o_frmcnt_dtt,       // Immediate only
  output logic [2:0]            o_engine_mode,
  output logic                  o_cmd_rnw,
  output logic                  o_cmd_wroc,
  output logic                  o_cmd_toc,
  output logic                  o_cmd_dbp,          // Regular only
  output logic                  o_cmd_sre           // Regular only
);

  import regf_pkg::*;

  cmd_desc_u desc;       // Word 0 seen both ways
  logic      immediate;

  assign desc      = i_desc_word0;
  assign immediate = desc.imm_view.attr[0];

  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_frmcnt_data_len <= '0;
      o_cmd_attr        <= '0;
      o_engine_tid      <= '0;
      o_ccc_cmd         <= '0;
      o_engine_cp       <= 1'b0;
      o_dev_index       <= '0;
      o_frmcnt_dtt      <= '0;
      o_engine_mode     <= '0;
      o_cmd_rnw         <= 1'b0;
      o_cmd_wroc        <= 1'b0;
      o_cmd_toc         <= 1'b0;
      o_cmd_dbp         <= 1'b0;
      o_cmd_sre         <= 1'b0;
    end
    else
    begin
      o_frmcnt_data_len <= i_desc_word1[31:16];  // Upper half of word 1

      // Fields common to both views
      o_cmd_attr    <= desc.imm_view.attr;
      o_engine_tid  <= desc.imm_view.tid;
      o_ccc_cmd     <= desc.imm_view.ccc;
      o_engine_cp   <= desc.imm_view.cp;
      o_dev_index   <= desc.imm_view.dev_index;
      o_engine_mode <= desc.imm_view.mode;
      o_cmd_rnw     <= desc.imm_view.rnw;
      o_cmd_wroc    <= desc.imm_view.wroc;
      o_cmd_toc     <= desc.imm_view.toc;

      if (immediate)
      begin
        o_frmcnt_dtt <= desc.imm_view.dtt;
        o_cmd_dbp    <= 1'b0;
        o_cmd_sre    <= 1'b0;
      end
      else
      begin
        o_frmcnt_dtt <= '0;  // Length comes from word 1
        o_cmd_dbp    <= desc.reg_view.dbp;
        o_cmd_sre    <= desc.reg_view.sre;
      end
    end
  end

endmodule

// File: source/regf_defaults.svh
// Reset values of the register array, non-zero bytes only
`ifndef REGF_DEFAULTS_SVH
`define REGF_DEFAULTS_SVH

mem[ADDR_TARGET]     <= 8'b1010_1000;  // Bit 0 clear, TX direction
mem[ADDR_NUM_FRAMES] <= 8'd2;
mem[ADDR_BDCST_WR]   <= 8'hFC;         // 7'h7E with write
mem[ADDR_BDCST_RD]   <= 8'hFD;         // 7'h7E with read
mem[ADDR_ENTDAA]     <= 8'h07;         // ENTDAA CCC code

// Hot-join event bytes
mem[ADDR_ENEC_CCC]   <= 8'h00;
mem[ADDR_ENEC_BYTE]  <= 8'b0000_1011;  // ENINT, ENCR, ENHJ
mem[ADDR_DISEC_CCC]  <= 8'h01;
mem[ADDR_DISEC_BYTE] <= 8'h00;
mem[ADDR_HJ_CFG]     <= 8'b0000_0111;
mem[ADDR_CRCAP1]     <= 8'h00;         // No hot-join capability

// Dummy descriptor, word 0 is an immediate command
mem[ADDR_DUMMY_DESC]         <= 8'b1000_0001;
mem[ADDR_DUMMY_DESC + 9'd1]  <= 8'b1000_1111;
mem[ADDR_DUMMY_DESC + 9'd2]  <= 8'b0000_0000;
mem[ADDR_DUMMY_DESC + 9'd3]  <= 8'b0001_1000;
// Word 1 zero, no payload
mem[ADDR_DUMMY_DESC + 9'd4]  <= 8'h00;
mem[ADDR_DUMMY_DESC + 9'd5]  <= 8'h00;
mem[ADDR_DUMMY_DESC + 9'd6]  <= 8'h00;
mem[ADDR_DUMMY_DESC + 9'd7]  <= 8'h00;

`endif

// File: source/regf_host_port.sv
// Host access port, registers strobes and drops cycles with both strobes high
`timescale 1ns/10ps

module regf_host_port (
  input  logic                 i_regf_clk,
  input  logic                 i_regf_rst_n,
  input  logic                 i_regf_rd_en,    // Read strobe from controller
  input  logic                 i_regf_wr_en,    // Write strobe from controller
  input  regf_pkg::regf_addr_t i_regf_addr,
  input  regf_pkg::regf_byte_t i_regf_data_wr,
  output regf_pkg::regf_byte_t o_regf_data_rd,  // Last read byte
  regf_access_if.host          acc
);

  import regf_pkg::*;

  logic rd_only;  // Read without a write in the same cycle
  logic wr_only;  // Write without a read
  logic one_hot;

  assign rd_only = i_regf_rd_en & ~i_regf_wr_en;
  assign wr_only = i_regf_wr_en & ~i_regf_rd_en;
  assign one_hot = rd_only | wr_only;

  //////////////////// Strobes
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      acc.rd <= 1'b0;  // No access out of reset
      acc.wr <= 1'b0;
    end
    else
    begin
      acc.rd <= rd_only;  // Collision gives neither
      acc.wr <= wr_only;
    end
  end

  //////////////////// Payload
  // Captured only for a real access, keeps last address otherwise
  always_ff @(posedge i_regf_clk)
  begin
    if (one_hot)
    begin
      acc.addr  <= i_regf_addr;
      acc.wdata <= i_regf_data_wr;
    end
  end

  // Read data comes back from storage register
  assign o_regf_data_rd = acc.rdata;

endmodule

// File: source/regf_pkg.sv
// Register file package with byte, address and descriptor types plus register map
package regf_pkg;

  //////////////////// Basic types
  typedef logic [7:0]  regf_byte_t;   // One register byte
  typedef logic [8:0]  regf_addr_t;   // 512-byte address space
  typedef logic [31:0] regf_dword_t;  // One descriptor word

  //////////////////// Descriptor word 0
  // Immediate command, bits 25..23 carry the data-transfer type
  typedef struct packed {
    logic       toc;        // Terminate on completion
    logic       wroc;       // Response on completion
    logic       rnw;        // 1 for read
    logic [2:0] mode;       // Bus mode
    logic [2:0] dtt;        // Data bytes in word 1
    logic [1:0] rsvd;
    logic [4:0] dev_index;  // Target table index
    logic       cp;         // CCC present
    logic [7:0] ccc;        // CCC code
    logic [3:0] tid;        // Transaction ID
    logic [2:0] attr;       // Bit 0 set for immediate
  } cmd_imm_t;

  // Regular command, bits 25 and 24 are DBP and SRE
  typedef struct packed {
    logic       toc;
    logic       wroc;
    logic       rnw;
    logic [2:0] mode;
    logic       dbp;        // Defining byte present
    logic       sre;        // Short read error allowed
    logic [2:0] rsvd;
    logic [4:0] dev_index;
    logic       cp;
    logic [7:0] ccc;
    logic [3:0] tid;
    logic [2:0] attr;
  } cmd_reg_t;

  // Same 32 bits, two decodings picked by attr[0]
  typedef union packed {
    cmd_imm_t imm_view;
    cmd_reg_t reg_view;
  } cmd_desc_u;

  //////////////////// Register map
  localparam regf_addr_t ADDR_TARGET     = 9'd0;    // Target address, bit 0 is RnW
  localparam regf_addr_t ADDR_NUM_FRAMES = 9'd1;
  localparam regf_addr_t ADDR_BDCST_WR   = 9'd46;   // 7'h7E + W
  localparam regf_addr_t ADDR_BDCST_RD   = 9'd47;   // 7'h7E + R
  localparam regf_addr_t ADDR_ENTDAA     = 9'd49;
  localparam regf_addr_t ADDR_ENEC_CCC   = 9'd401;
  localparam regf_addr_t ADDR_ENEC_BYTE  = 9'd402;
  localparam regf_addr_t ADDR_DISEC_CCC  = 9'd403;
  localparam regf_addr_t ADDR_DISEC_BYTE = 9'd404;
  localparam regf_addr_t ADDR_HJ_CFG     = 9'd405;
  localparam regf_addr_t ADDR_CRCAP1     = 9'd409;
  localparam regf_addr_t ADDR_DUMMY_DESC = 9'd450;  // Fixed 8-byte descriptor

  localparam int HJ_BIT = 3;  // ENHJ / DISHJ position in event byte

endpackage

// File: source/regf_storage.sv
// Register storage with host reads and writes, hot-join bits, status and descriptor fetch
`timescale 1ns/10ps

module regf_storage #(
  parameter int REGF_DEPTH = 512  // Bytes held, 460 up to 512
) (
  input  logic                  i_regf_clk,
  input  logic                  i_regf_rst_n,
  regf_access_if.store          acc,
  input  regf_pkg::regf_addr_t  i_engine_configuration,  // Descriptor base
  output regf_pkg::regf_dword_t o_desc_word0,
  output regf_pkg::regf_dword_t o_desc_word1,
  output regf_pkg::regf_byte_t  o_regf_num_frames,
  output logic                  o_ser_rx_tx,              // 1 for RX
  output logic [2:0]            o_regf_hj_cfg,
  output logic                  o_regf_hj_support
);

  import regf_pkg::*;

  regf_byte_t mem [REGF_DEPTH];  // Byte array
  logic       hj_enable;         // Capable and enabled

  // Bytes past the array end read as zero
  function automatic regf_byte_t byte_at(input regf_addr_t a);
    if (int'(a) < REGF_DEPTH)
    begin
      return mem[a];
    end
    return '0;
  endfunction

  // CRCAP1[0] is capability, HJ_CFG[1] is enable
  assign hj_enable = mem[ADDR_CRCAP1][0] & mem[ADDR_HJ_CFG][1];

  //////////////////// Array
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      for (int i = 0; i < REGF_DEPTH; i++)
      begin
        mem[i] <= '0;
      end
      `include "regf_defaults.svh"
    end
    else
    begin
      // Host write, at most one of rd and wr is set
      if (acc.wr && (int'(acc.addr) < REGF_DEPTH))
      begin
        mem[acc.addr] <= acc.wdata;
      end

      // Defining bits win over a host write at the same edge
      mem[ADDR_ENEC_BYTE][HJ_BIT]  <= hj_enable;   // ENHJ
      mem[ADDR_DISEC_BYTE][HJ_BIT] <= ~hj_enable;  // DISHJ
    end
  end

  //////////////////// Read data
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      acc.rdata <= '0;
    end
    else if (acc.rd)
    begin
      acc.rdata <= byte_at(acc.addr);  // Held until next read
    end
  end

  //////////////////// Status
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_regf_num_frames <= '0;
      o_ser_rx_tx       <= 1'b0;
    end
    else
    begin
      o_regf_num_frames <= mem[ADDR_NUM_FRAMES];
      o_ser_rx_tx       <= mem[ADDR_TARGET][0];  // RnW bit of target address
    end
  end

  // Hot-join settings straight from the array
  assign o_regf_hj_cfg     = mem[ADDR_HJ_CFG][2:0];
  assign o_regf_hj_support = mem[ADDR_CRCAP1][0];

  //////////////////// Descriptor fetch
  // Eight bytes from the base, little-endian, address wraps at 512
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      o_desc_word0[8*k +: 8] = byte_at(i_engine_configuration + regf_addr_t'(k));
      o_desc_word1[8*k +: 8] = byte_at(i_engine_configuration + regf_addr_t'(k + 4));
    end
  end

endmodule

// File: source/regf_top.sv
// Register file top level, host port, storage and descriptor decoder
`timescale 1ns/10ps

module regf_top #(
  parameter int REGF_DEPTH = 512
) (
  input  logic                 i_regf_clk,
  input  logic                 i_regf_rst_n,
  // Host access
  input  logic                 i_regf_rd_en,
  input  logic                 i_regf_wr_en,
  input  regf_pkg::regf_addr_t i_regf_addr,
  input  regf_pkg::regf_byte_t i_regf_data_wr,
  output regf_pkg::regf_byte_t o_regf_data_rd,
  // Engine
  input  regf_pkg::regf_addr_t i_engine_configuration,
  // Status
  output regf_pkg::regf_byte_t o_regf_num_frames,
  output logic                 o_ser_rx_tx,
  output logic [2:0]           o_regf_hj_cfg,
  output logic                 o_regf_hj_support,
  // Decoded command
  output logic [15:0]          o_frmcnt_data_len,
  output logic [2:0]           o_cmd_attr,
  output logic [3:0]           o_engine_tid,
  output logic [7:0]           o_ccc_cmd,
  output logic                 o_engine_cp,
  output logic [4:0]           o_dev_index,
  output logic [2:0]           o_frmcnt_dtt,
  output logic [2:0]           o_engine_mode,
  output logic                 o_cmd_rnw,
  output logic                 o_cmd_wroc,
  output logic                 o_cmd_toc,
  output logic                 o_cmd_dbp,
  output logic                 o_cmd_sre
);

  import regf_pkg::*;

  regf_dword_t desc_word0;  // Descriptor words at the base
  regf_dword_t desc_word1;

  regf_access_if acc ();

  regf_host_port u_host_port (
    .i_regf_clk     (i_regf_clk),
    .i_regf_rst_n   (i_regf_rst_n),
    .i_regf_rd_en   (i_regf_rd_en),
    .i_regf_wr_en   (i_regf_wr_en),
    .i_regf_addr    (i_regf_addr),
    .i_regf_data_wr (i_regf_data_wr),
    .o_regf_data_rd (o_regf_data_rd),
    .acc            (acc.host)
  );

  regf_storage #(
    .REGF_DEPTH (REGF_DEPTH)
  ) u_storage (
    .i_regf_clk             (i_regf_clk),
    .i_regf_rst_n           (i_regf_rst_n),
    .acc                    (acc.store),
    .i_engine_configuration (i_engine_configuration),
    .o_desc_word0           (desc_word0),
    .o_desc_word1           (desc_word1),
    .o_regf_num_frames      (o_regf_num_frames),
    .o_ser_rx_tx            (o_ser_rx_tx),
    .o_regf_hj_cfg          (o_regf_hj_cfg),
    .o_regf_hj_support      (o_regf_hj_support)
  );

  regf_cmd_decode u_cmd_decode (
    .i_regf_clk        (i_regf_clk),
    .i_regf_rst_n      (i_regf_rst_n),
    .i_desc_word0      (desc_word0),
    .i_desc_word1      (desc_word1),
    .o_frmcnt_data_len (o_frmcnt_data_len),
    .o_cmd_attr        (o_cmd_attr),
    .o_engine_tid      (o_engine_tid),
    .o_ccc_cmd         (o_ccc_cmd),
    .o_engine_cp       (o_engine_cp),
    .o_dev_index       (o_dev_index),
    .o_frmcnt_dtt      (o_frmcnt_dtt),
    .o_engine_mode     (o_engine_mode),
    .o_cmd_rnw         (o_cmd_rnw),
    .o_cmd_wroc        (o_cmd_wroc),
    .o_cmd_toc         (o_cmd_toc),
    .o_cmd_dbp         (o_cmd_dbp),
    .o_cmd_sre         (o_cmd_sre)
  );

endmodule
